// File: Makefile
VERILATOR ?= verilator
TOP       ?= disk_ctrl_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard sim/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/disk_ctrl_tasks.svh
`ifndef DISK_CTRL_TASKS_SVH
`define DISK_CTRL_TASKS_SVH

	// Partition table fill, rising with the entry index
	function automatic logic [31:0] header_entry(input int k);
		return 32'h0012_0000 + 32'(k) * 32'd2048;
	endfunction

	// Signature words carry their bytes swapped
	task automatic build_header_image(input logic [7:0] version);
		logic [31:0] sig;
		logic [31:0] entry;
		sig = "BKHD";
		for (int w = 0; w < 256; w++) begin
			entry = header_entry(w / 2);
			hdr_image[w] = w[0] ? entry[31:16] : entry[15:0];
		end
		hdr_image[0] = {sig[23:16], sig[31:24]};
		hdr_image[1] = {sig[7:0], sig[15:8]};
		hdr_image[2] = {8'h00, version};
		hdr_image[3] = 16'h0000;
	endtask

	// SD host side of a sector 0 read
	task automatic load_header(input logic [7:0] version);
		int n;
		build_header_image(version);
		img_mounted[0] = 1'b1;
		tick();
		img_mounted[0] = 1'b0;
		n = 0;
		while (hdr_rd !== 1'b1) begin
			if (n == WAIT_LIMIT) begin
				abort_on_timeout("hdr_rd");
			end
			tick();
			n++;
		end
		sd_ack = 1'b1;
		tick();
		check_bit("hdr_rd", hdr_rd, 1'b0);
		for (int w = 0; w < 256; w++) begin
			sd_buff_addr = 8'(w);
			sd_buff_dout = hdr_image[w];
			sd_buff_wr = 1'b1;
			tick();
		end
		sd_buff_wr = 1'b0;
		tick();
		sd_ack = 1'b0;
		tick();
	endtask

	task automatic mount_floppy(input int idx, input logic [31:0] size, input logic readonly);
		img_size = size;
		img_readonly = readonly;
		img_mounted[idx + 1] = 1'b1;
		tick();
		img_mounted[idx + 1] = 1'b0;
		img_size = '0;
		img_readonly = 1'b0;
		tick();
	endtask

`endif

// File: sim/disk_ctrl_tb.sv
`timescale 1ns/1ps

module disk_ctrl_tb;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 1;
	localparam int WAIT_LIMIT = 40;

	localparam logic [1:0] S_NONE = 2'd0;
	localparam logic [1:0] S_FD = 2'd1;
	localparam logic [1:0] S_HDR = 2'd2;
	localparam logic [1:0] S_BAD = 2'd3;

	localparam disk_pkg::disk_err_e E_NONE = disk_pkg::ERR_NONE;
	localparam disk_pkg::disk_err_e E_RO = disk_pkg::ERR_READONLY;
	localparam disk_pkg::disk_err_e E_RANGE = disk_pkg::ERR_RANGE;
	localparam disk_pkg::disk_err_e E_NODISK = disk_pkg::ERR_NO_DISK;
	localparam disk_pkg::disk_err_e E_ARGS = disk_pkg::ERR_BAD_ARGS;

	typedef struct packed {
		logic [1:0]           setup;
		disk_pkg::disk_req_t  req;
		logic [7:0]           stall;
		logic                 geom_free;  // lba and mask undefined for bad disk numbers
		disk_pkg::disk_resp_t expected;
	} row_t;

	logic                 clk_sys;
	logic                 reset;
	disk_pkg::disk_req_t  req;
	logic                 req_valid;
	logic                 req_ready;
	disk_pkg::disk_resp_t resp;
	logic                 resp_valid;
	logic                 resp_ready;
	logic                 hdr_rd;
	logic                 sd_ack;
	logic [7:0]           sd_buff_addr;
	logic [15:0]          sd_buff_dout;
	logic                 sd_buff_wr;
	logic [2:0]           img_mounted;
	logic                 img_readonly;
	logic [31:0]          img_size;

	row_t        rows [$];
	logic [15:0] hdr_image [256];
	int          seed;
	int          mismatches;
	int          failures;

	disk_ctrl #(
		.HDR_ENTRIES(128)
	) UUT (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.req         (req),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.resp        (resp),
		.resp_valid  (resp_valid),
		.resp_ready  (resp_ready),
		.hdr_rd      (hdr_rd),
		.sd_ack      (sd_ack),
		.sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout),
		.sd_buff_wr  (sd_buff_wr),
		.img_mounted (img_mounted),
		.img_readonly(img_readonly),
		.img_size    (img_size)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	task automatic tick();
		@(posedge clk_sys);
		#DRIVE_DELAY;
	endtask

	task automatic check_field(input string name, input logic [63:0] got, input logic [63:0] want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, want);
			mismatches++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, want);
			mismatches++;
		end
	endtask

	task automatic finish_run();
		$display("Summary: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		failures++;
		$display("Timed out at %0t waiting for %s", $time, what);
		finish_run();
	endtask

	task automatic check_idle_outputs();
		check_bit("req_ready", req_ready, 1'b0);
		check_bit("resp_valid", resp_valid, 1'b0);
		check_bit("hdr_rd", hdr_rd, 1'b0);
	endtask

	`include "disk_ctrl_tasks.svh"

	task automatic add_row(input logic [1:0] setup, input int disk, input int start_block,
			input int length, input int buf_addr, input int geom_free,
			input disk_pkg::disk_err_e err, input logic [31:0] lba, input int blocks,
			input logic [2:0] mask, input logic write);
		row_t r;
		r.setup = setup;
		r.req.disk = 8'(disk);
		r.req.start_block = 16'(start_block);
		r.req.length = 16'(length);
		r.req.buf_addr = 16'(buf_addr);
		r.stall = 8'($unsigned($random(seed)) % 5);
		r.geom_free = geom_free != 0;
		r.expected.err = err;
		r.expected.lba = lba;
		r.expected.blocks = 8'(blocks);
		r.expected.drive_mask = mask;
		r.expected.write = write;
		rows.push_back(r);
	endtask

	task automatic build_table();
		// Nothing mounted yet
		add_row(S_NONE, 0, 0, 256, 16'h1000, 0, E_NODISK, 0, 1, 3'b010, 0);
		add_row(S_NONE, 1, 5, 16'hFE00, 16'h2000, 0, E_NODISK, 5, 2, 3'b100, 1);
		add_row(S_NONE, 0, 0, 0, 16'h0001, 0, E_NODISK, 0, 0, 3'b010, 0);
		// Floppy 0 is 800 blocks writable, floppy 1 is 1600 blocks read-only
		add_row(S_FD, 0, 10, 256, 16'h1000, 0, E_NONE, 10, 1, 3'b010, 0);
		add_row(S_NONE, 0, 100, 16'hFC00, 16'h1000, 0, E_NONE, 100, 4, 3'b010, 1);
		add_row(S_NONE, 0, 798, 257, 16'h0200, 0, E_NONE, 798, 2, 3'b010, 0);
		add_row(S_NONE, 0, 799, 257, 16'h0200, 0, E_RANGE, 799, 2, 3'b010, 0);
		add_row(S_NONE, 0, 900, 1, 16'h0100, 0, E_RANGE, 900, 1, 3'b010, 0);
		add_row(S_NONE, 1, 0, 16'h7FFF, 16'h4000, 0, E_NONE, 0, 128, 3'b100, 0);
		add_row(S_NONE, 1, 3, 16'hFF00, 16'h4000, 0, E_RO, 3, 1, 3'b100, 1);
		add_row(S_NONE, 1, 1599, 16'hFE00, 16'h4000, 0, E_RANGE, 1599, 2, 3'b100, 1);
		add_row(S_NONE, 0, 0, 0, 16'h1000, 0, E_ARGS, 0, 0, 3'b010, 0);
		add_row(S_NONE, 0, 0, 256, 16'h1001, 0, E_ARGS, 0, 1, 3'b010, 0);
		add_row(S_NONE, 1, 0, 16'hFF00, 16'h0003, 0, E_ARGS, 0, 1, 3'b100, 1);
		add_row(S_NONE, 1, 1700, 0, 16'h0003, 0, E_ARGS, 1700, 0, 3'b100, 0);
		// Header with a valid signature and version
		add_row(S_HDR, 2, 0, 256, 16'h1000, 0, E_NONE, header_entry(4), 1, 3'b001, 0);
		add_row(S_NONE, 2, 2047, 16'hFF00, 16'h1000, 0,
			E_NONE, header_entry(4) + 2047, 1, 3'b001, 1);
		add_row(S_NONE, 2, 2047, 512, 16'h1000, 0,
			E_RANGE, header_entry(4) + 2047, 2, 3'b001, 0);
		add_row(S_NONE, 10, 7, 300, 16'h1000, 0, E_NONE, header_entry(12) + 7, 2, 3'b001, 0);
		add_row(S_NONE, 124, 0, 256, 16'h1000, 0, E_NONE, header_entry(126), 1, 3'b001, 0);
		add_row(S_NONE, 125, 0, 256, 16'h1000, 1, E_NODISK, 0, 1, 3'b001, 0);
		add_row(S_NONE, 125, 0, 0, 16'h0001, 1, E_NODISK, 0, 0, 3'b001, 0);
		add_row(S_NONE, 3, 0, 0, 16'h1000, 0, E_ARGS, header_entry(5), 0, 3'b001, 0);
		add_row(S_NONE, 0, 1, 256, 16'h1000, 0, E_NONE, 1, 1, 3'b010, 0);
		// Reload with version 2
		add_row(S_BAD, 2, 0, 256, 16'h1000, 0, E_NODISK, header_entry(4), 1, 3'b001, 0);
		add_row(S_NONE, 1, 0, 256, 16'h1000, 0, E_NONE, 0, 1, 3'b100, 0);
	endtask

	task automatic wait_req_ready();
		int n;
		n = 0;
		while (req_ready !== 1'b1) begin
			if (n == WAIT_LIMIT) begin
				abort_on_timeout("req_ready");
			end
			tick();
			n++;
		end
	endtask

	task automatic apply_row(input row_t r);
		int                   cycles;
		disk_pkg::disk_resp_t held;
		wait_req_ready();
		req = r.req;
		req_valid = 1'b1;
		tick();
		req_valid = 1'b0;
		req = '0;
		cycles = 0;
		while (resp_valid !== 1'b1) begin
			check_bit("req_ready", req_ready, 1'b0);
			if (cycles == WAIT_LIMIT) begin
				abort_on_timeout("resp_valid");
			end
			tick();
			cycles++;
		end
		check_field("resp latency", 64'(cycles), 64'd3);
		check_field("resp.err", 64'(resp.err), 64'(r.expected.err));
		if (!r.geom_free) begin
			check_field("resp.lba", 64'(resp.lba), 64'(r.expected.lba));
			check_field("resp.drive_mask", 64'(resp.drive_mask), 64'(r.expected.drive_mask));
		end
		check_field("resp.blocks", 64'(resp.blocks), 64'(r.expected.blocks));
		check_bit("resp.write", resp.write, r.expected.write);
		held = resp;
		// Back-pressure
		repeat (r.stall) begin
			tick();
			check_bit("resp_valid", resp_valid, 1'b1);
			check_bit("req_ready", req_ready, 1'b0);
			check_field("resp", 64'(resp), 64'(held));
		end
		resp_ready = 1'b1;
		tick();
		resp_ready = 1'b0;
		check_bit("resp_valid", resp_valid, 1'b0);
		check_bit("req_ready", req_ready, 1'b1);
	endtask

	initial begin
		seed = 19;
		mismatches = 0;
		failures = 0;
		reset = 1'b1;
		req = '0;
		req_valid = 1'b0;
		resp_ready = 1'b0;
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
		img_mounted = '0;
		img_readonly = 1'b0;
		img_size = '0;
		build_table();
		repeat (8) begin
			tick();
			check_idle_outputs();
		end
		reset = 1'b0;
		check_idle_outputs();
		tick();
		check_bit("req_ready", req_ready, 1'b1);
		foreach (rows[i]) begin
			case (rows[i].setup)
				S_FD: begin
					mount_floppy(0, 800, 1'b0);
					mount_floppy(1, 1600, 1'b1);
				end
				S_HDR: load_header(8'd1);
				S_BAD: load_header(8'd2);
				default: ;
			endcase
			apply_row(rows[i]);
		end
		finish_run();
	end

endmodule

// File: src.f
+incdir+sim
verilog/disk_pkg.sv
verilog/sector_dpram.sv
verilog/disk_request_parser.sv
verilog/disk_mount_table.sv
verilog/disk_request_check.sv
verilog/disk_ctrl.sv
sim/disk_ctrl_tb.sv

// File: verilog/disk_ctrl.sv
`timescale 1ns/1ps

module disk_ctrl #(
	parameter int HDR_ENTRIES = 128
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  disk_pkg::disk_req_t  req,
	input  logic                 req_valid,
	output logic                 req_ready,
	output disk_pkg::disk_resp_t resp,
	output logic                 resp_valid,
	input  logic                 resp_ready,
	output logic                 hdr_rd,
	input  logic                 sd_ack,
	input  logic [7:0]           sd_buff_addr,
	input  logic [15:0]          sd_buff_dout,
	input  logic                 sd_buff_wr,
	input  logic [2:0]           img_mounted,
	input  logic                 img_readonly,
	input  logic [31:0]          img_size
);

	logic                   req_fire;
	logic                   hdr_loading;
	disk_pkg::disk_parsed_t parsed;
	disk_pkg::disk_geom_t   geom;

	disk_request_parser u_parser (
		.clk_sys (clk_sys),
		.reset   (reset),
		.req     (req),
		.req_fire(req_fire),
		.parsed  (parsed)
	);

	disk_mount_table #(
		.HDR_ENTRIES(HDR_ENTRIES)
	) u_mount (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.req_fire    (req_fire),
		.disk        (req.disk),
		.sd_ack      (sd_ack),
		.sd_buff_addr(sd_buff_addr),
		.sd_buff_dout(sd_buff_dout),
		.sd_buff_wr  (sd_buff_wr),
		.img_mounted (img_mounted),
		.img_readonly(img_readonly),
		.img_size    (img_size),
		.hdr_rd      (hdr_rd),
		.hdr_loading (hdr_loading),
		.geom        (geom)
	);

	disk_request_check u_check (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.req_valid  (req_valid),
		.hdr_loading(hdr_loading),
		.parsed     (parsed),
		.geom       (geom),
		.resp_ready (resp_ready),
		.req_ready  (req_ready),
		.req_fire   (req_fire),
		.resp       (resp),
		.resp_valid (resp_valid)
	);

endmodule

// File: verilog/disk_mount_table.sv
`timescale 1ns/1ps

module disk_mount_table #(
	parameter int HDR_ENTRIES = 128
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 req_fire,
	input  logic [7:0]           disk,
	input  logic                 sd_ack,
	input  logic [7:0]           sd_buff_addr,
	input  logic [15:0]          sd_buff_dout,
	input  logic                 sd_buff_wr,
	input  logic [2:0]           img_mounted,
	input  logic                 img_readonly,
	input  logic [31:0]          img_size,
	output logic                 hdr_rd,
	output logic                 hdr_loading,
	output disk_pkg::disk_geom_t geom
);

	localparam int AW = $clog2(HDR_ENTRIES);

	disk_pkg::mount_state_e mnt_state;

	logic [2:0]    old_mounted;
	logic [2:0]    mount_rise;
	logic          hd_mounted;
	logic [31:0]   hdr_sig;
	logic [7:0]    hdr_ver;
	logic          hdr_wr;
	logic [31:0]   fd_size [disk_pkg::FLOPPY_COUNT];
	logic          fd_ro [disk_pkg::FLOPPY_COUNT];
	logic [AW-1:0] rd_addr;
	logic [31:0]   rd_data;
	logic          fetch_end;
	logic          fetch_done;
	logic          is_floppy;
	logic          fd_idx;
	logic [31:0]   part_start;

	assign mount_rise = img_mounted & ~old_mounted;
	assign hdr_loading = mnt_state != disk_pkg::MNT_IDLE;
	assign hdr_wr = hdr_loading && sd_ack && sd_buff_wr;

	always_ff @(posedge clk_sys) begin
		old_mounted <= img_mounted;
	end

	// Header load, hdr_rd drops once the host acknowledges
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mnt_state <= disk_pkg::MNT_IDLE;
			hdr_rd <= 1'b0;
			hd_mounted <= 1'b0;
		end else begin
			case (mnt_state)
				disk_pkg::MNT_IDLE: begin
					if (mount_rise[0]) begin
						hd_mounted <= 1'b0;
						hdr_rd <= 1'b1;
						mnt_state <= disk_pkg::MNT_REQ;
					end
				end
				disk_pkg::MNT_REQ: begin
					if (sd_ack) begin
						hdr_rd <= 1'b0;
						mnt_state <= disk_pkg::MNT_XFER;
					end
				end
				disk_pkg::MNT_XFER: begin
					if (!sd_ack) begin
						hd_mounted <= (hdr_sig == disk_pkg::HDR_SIGNATURE) &&
							(hdr_ver == disk_pkg::HDR_VERSION);
						mnt_state <= disk_pkg::MNT_IDLE;
					end
				end
				default: begin
					mnt_state <= disk_pkg::MNT_IDLE;
				end
			endcase
		end
	end

	// Signature words are stored big endian
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			case (sd_buff_addr)
				8'd0: hdr_sig[31:16] <= {sd_buff_dout[7:0], sd_buff_dout[15:8]};
				8'd1: hdr_sig[15:0] <= {sd_buff_dout[7:0], sd_buff_dout[15:8]};
				8'd2: hdr_ver <= sd_buff_dout[7:0];
				default: ;
			endcase
		end
	end

	// Floppy images on mount bits 1 and 2
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < disk_pkg::FLOPPY_COUNT; i++) begin
				fd_size[i] <= '0;
				fd_ro[i] <= 1'b0;
			end
		end else begin
			for (int i = 0; i < disk_pkg::FLOPPY_COUNT; i++) begin
				if (mount_rise[i + 1]) begin
					fd_size[i] <= img_size;
					fd_ro[i] <= img_readonly;
				end
			end
		end
	end

	sector_dpram #(
		.WORDS(HDR_ENTRIES),
		.WW   (16),
		.RW   (32)
	) u_hdr_ram (
		.clk_sys(clk_sys),
		.wr_en  (hdr_wr),
		.wr_addr(sd_buff_addr),
		.wr_data(sd_buff_dout),
		.rd_addr(rd_addr),
		.rd_data(rd_data)
	);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fetch_end <= 1'b0;
			fetch_done <= 1'b0;
		end else begin
			fetch_end <= req_fire;
			fetch_done <= fetch_end;
		end
	end

	// Start entry addressed at accept, end entry one cycle later
	always_ff @(posedge clk_sys) begin
		if (req_fire) begin
			rd_addr <= AW'(disk) + AW'(disk_pkg::HDR_ENTRY_BASE);
			is_floppy <= disk < 8'(disk_pkg::FLOPPY_COUNT);
			fd_idx <= disk[0];
		end else if (fetch_end) begin
			rd_addr <= rd_addr + 1'b1;
		end
		if (fetch_done) begin
			part_start <= rd_data;
		end
	end

	always_comb begin
		if (is_floppy) begin
			geom.start = '0;
			geom.end_lba = fd_size[fd_idx];
			geom.readonly = fd_ro[fd_idx];
			geom.drive_mask = 3'b010 << fd_idx;
		end else begin
			geom.start = part_start;
			geom.end_lba = hd_mounted ? rd_data : '0;
			geom.readonly = 1'b0;
			geom.drive_mask = 3'b001;
		end
	end

	a_hdr_rd_from_idle: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(hdr_rd) |-> $past(mnt_state) == disk_pkg::MNT_IDLE);

endmodule

// File: verilog/disk_pkg.sv
package disk_pkg;

	// Error codes returned to the caller
	typedef enum logic [7:0] {
		ERR_NONE     = 8'd0,
		ERR_READONLY = 8'd1,
		ERR_RANGE    = 8'd5,
		ERR_NO_DISK  = 8'd6,
		ERR_BAD_ARGS = 8'd10
	} disk_err_e;

	typedef enum logic [1:0] {
		MNT_IDLE,
		MNT_REQ,
		MNT_XFER
	} mount_state_e;

	typedef struct packed {
		logic [7:0]  disk;
		logic [15:0] start_block;
		logic [15:0] length;      // negative means write
		logic [15:0] buf_addr;
	} disk_req_t;

	typedef struct packed {
		logic [15:0] start_block;
		logic [7:0]  blocks;
		logic        write;
		logic        bad_args;
		logic        bad_disk;
	} disk_parsed_t;

	// end_lba is exclusive, zero when nothing is mounted
	typedef struct packed {
		logic [31:0] start;
		logic [31:0] end_lba;
		logic        readonly;
		logic [2:0]  drive_mask;
	} disk_geom_t;

	typedef struct packed {
		disk_err_e   err;
		logic [31:0] lba;
		logic [7:0]  blocks;
		logic [2:0]  drive_mask;
		logic        write;
	} disk_resp_t;

	localparam logic [31:0] HDR_SIGNATURE  = "BKHD";
	localparam logic [7:0]  HDR_VERSION    = 8'd1;
	localparam int          FLOPPY_COUNT   = 2;
	localparam int          DISK_LIMIT     = 125;
	localparam int          SECTOR_WORDS   = 256;
	localparam int          HDR_ENTRY_BASE = 2;

endpackage

// File: verilog/disk_request_check.sv
`timescale 1ns/1ps

module disk_request_check (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   req_valid,
	input  logic                   hdr_loading,
	input  disk_pkg::disk_parsed_t parsed,
	input  disk_pkg::disk_geom_t   geom,
	input  logic                   resp_ready,
	output logic                   req_ready,
	output logic                   req_fire,
	output disk_pkg::disk_resp_t   resp,
	output logic                   resp_valid
);

	typedef enum logic [2:0] {
		CHK_INIT,
		CHK_IDLE,
		CHK_START,
		CHK_END,
		CHK_EVAL,
		CHK_RESP
	} chk_state_e;

	chk_state_e         state;
	disk_pkg::disk_err_e err;
	logic [31:0]        lba;
	logic [32:0]        span_end;

	// Header RAM has one read port, so one request at a time
	assign req_ready = (state == CHK_IDLE) && !hdr_loading;
	assign req_fire = req_ready && req_valid;
	assign resp_valid = state == CHK_RESP;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= CHK_INIT;
		end else begin
			case (state)
				CHK_INIT: state <= CHK_IDLE;
				CHK_IDLE: begin
					if (req_fire) begin
						state <= CHK_START;
					end
				end
				CHK_START: state <= CHK_END;
				CHK_END: state <= CHK_EVAL;
				CHK_EVAL: state <= CHK_RESP;
				CHK_RESP: begin
					if (resp_ready) begin
						state <= CHK_IDLE;
					end
				end
				default: state <= CHK_INIT;
			endcase
		end
	end

	always_comb begin
		lba = geom.start + 32'(parsed.start_block);
		span_end = {1'b0, lba} + 33'(parsed.blocks);

		// First matching rule wins
		if (parsed.bad_disk || geom.end_lba == '0) begin
			err = disk_pkg::ERR_NO_DISK;
		end else if (parsed.bad_args) begin
			err = disk_pkg::ERR_BAD_ARGS;
		end else if (span_end > {1'b0, geom.end_lba}) begin
			err = disk_pkg::ERR_RANGE;
		end else if (parsed.write && geom.readonly) begin
			err = disk_pkg::ERR_READONLY;
		end else begin
			err = disk_pkg::ERR_NONE;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state == CHK_EVAL) begin
			resp.err <= err;
			resp.lba <= lba;
			resp.blocks <= parsed.blocks;
			resp.drive_mask <= geom.drive_mask;
			resp.write <= parsed.write;
		end
	end

	a_resp_hold: assert property (@(posedge clk_sys) disable iff (reset)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp));

	a_ready_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(req_ready && resp_valid));

endmodule

// File: verilog/disk_request_parser.sv
`timescale 1ns/1ps

module disk_request_parser (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  disk_pkg::disk_req_t    req,
	input  logic                   req_fire,
	output disk_pkg::disk_parsed_t parsed
);

	localparam int SECTOR_SHIFT = $clog2(disk_pkg::SECTOR_WORDS);

	logic [15:0]            words;
	logic [16:0]            words_up;
	disk_pkg::disk_parsed_t next_parsed;

	always_comb begin
		// Length is two's complement, negative for a write
		words = req.length[15] ? (~req.length + 16'd1) : req.length;
		words_up = {1'b0, words} + 17'(disk_pkg::SECTOR_WORDS - 1);

		next_parsed.start_block = req.start_block;
		next_parsed.blocks = 8'(words_up >> SECTOR_SHIFT);
		next_parsed.write = req.length[15];
		next_parsed.bad_args = (words == 16'd0) || req.buf_addr[0];
		next_parsed.bad_disk = req.disk >= 8'(disk_pkg::DISK_LIMIT);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			parsed <= '0;
		end else if (req_fire) begin
			parsed <= next_parsed;
		end
	end

endmodule

// File: verilog/sector_dpram.sv
`timescale 1ns/1ps

module sector_dpram #(
	parameter int WORDS = 128,
	parameter int WW    = 16,
	parameter int RW    = 32
) (
	input  logic                                clk_sys,
	input  logic                                wr_en,
	input  logic [$clog2(WORDS * RW / WW)-1:0]  wr_addr,
	input  logic [WW-1:0]                       wr_data,
	input  logic [$clog2(WORDS)-1:0]            rd_addr,
	output logic [RW-1:0]                       rd_data
);

	// Narrow writes per wide read word
	localparam int R = RW / WW;

	logic [R-1:0][WW-1:0] mem [WORDS];

	// Lower write address lands in the low half of the read word
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[wr_addr / R][wr_addr % R] <= wr_data;
		end
		rd_data <= mem[rd_addr];
	end

endmodule
